// File: core_datapath.sv
// Top level of the operand front: register file, decode, operand muxes and execute
`timescale 1ns/1ps

module core_datapath import op_pkg::*; (
	input  logic   clk,
	input  logic   rst_n,
	input  logic   issue_valid,
	input  logic   hold,
	input  issue_t issue,
	output logic   issue_ready,
	output wb_t    wb
);

	// Freeze pair
	logic     id_freeze;
	logic     ex_freeze;
	// ID to register file and muxes
	reg_idx_t ra;
	reg_idx_t rb;
	opsel_t   sel_a;
	opsel_t   sel_b;
	word_t    simm;
	word_t    rf_data_a;
	word_t    rf_data_b;
	// EX side
	ex_ctrl_t ex_ctrl;
	ex_ctrl_t ex_dst;
	word_t    operand_a;
	word_t    operand_b;
	word_t    ex_forw;
	word_t    wb_forw;

	////////////////////
	// Stages
	////////////////////

	regfile u_regfile (
		.clk(clk), .rst_n(rst_n),
		.rd_idx_a(ra), .rd_idx_b(rb),
		.rd_data_a(rf_data_a), .rd_data_b(rf_data_b),
		.wr(wb)
	);

	issue_decode u_decode (
		.clk(clk), .rst_n(rst_n), .issue_valid(issue_valid), .hold(hold),
		.issue(issue), .issue_ready(issue_ready),
		.id_freeze(id_freeze), .ex_freeze(ex_freeze), .ra(ra), .rb(rb),
		.sel_a(sel_a), .sel_b(sel_b), .simm(simm),
		.ex_ctrl(ex_ctrl), .ex_dst(ex_dst), .wb_dst(wb)
	);

	operand_muxes u_muxes (
		.clk(clk), .rst_n(rst_n), .id_freeze(id_freeze), .ex_freeze(ex_freeze),
		.rf_data_a(rf_data_a), .rf_data_b(rf_data_b),
		.ex_forw(ex_forw), .wb_forw(wb_forw), .simm(simm),
		.sel_a(sel_a), .sel_b(sel_b), .operand_a(operand_a), .operand_b(operand_b)
	);

	exec_stage u_exec (
		.clk(clk), .rst_n(rst_n), .ex_freeze(ex_freeze), .ex_ctrl(ex_ctrl),
		.operand_a(operand_a), .operand_b(operand_b), .ex_dst(ex_dst),
		.ex_forw(ex_forw), .wb_forw(wb_forw), .wb(wb)
	);

endmodule

// File: datapath_properties.sv
// Concurrent assertions on hold, operand freeze and saved-operand behavior, with bind
`timescale 1ns/1ps

module datapath_properties import op_pkg::*; (
	input logic  clk,
	input logic  rst_n,
	input logic  hold,
	input logic  ex_freeze,
	input logic  id_freeze,
	input logic  saved_a,
	input logic  saved_b,
	input wb_t   wb,
	input word_t operand_a,
	input word_t operand_b
);

	// No result leaves WB under hold
	a_wb_idle_on_hold: assert property (@(posedge clk) disable iff (!rst_n)
		hold |-> !wb.valid)
		else $error("wb.valid high while hold is set");

	// Operand registers keep their value through a full freeze
	a_hold_keeps_opnd: assert property (@(posedge clk) disable iff (!rst_n)
		ex_freeze |=> $stable(operand_a) && $stable(operand_b))
		else $error("operand changed across ex_freeze");

	// Captured operands survive the rest of an ID-only freeze
	a_saved_keeps_a: assert property (@(posedge clk) disable iff (!rst_n)
		saved_a && id_freeze |=> $stable(operand_a))
		else $error("operand_a overwritten while saved");

	a_saved_keeps_b: assert property (@(posedge clk) disable iff (!rst_n)
		saved_b && id_freeze |=> $stable(operand_b))
		else $error("operand_b overwritten while saved");

endmodule

bind core_datapath datapath_properties props_i (
	.clk(clk), .rst_n(rst_n), .hold(hold), .ex_freeze(ex_freeze), .id_freeze(id_freeze),
	.saved_a(u_muxes.saved_q[0]), .saved_b(u_muxes.saved_q[1]),
	.wb(wb), .operand_a(operand_a), .operand_b(operand_b)
);

// File: exec_stage.sv
// EX stage: control register, ALU and the WB result register
`timescale 1ns/1ps

module exec_stage import op_pkg::*; (
	input  logic     clk,
	input  logic     rst_n,
	input  logic     ex_freeze,
	input  ex_ctrl_t ex_ctrl,
	input  word_t    operand_a,
	input  word_t    operand_b,
	output ex_ctrl_t ex_dst,
	output word_t    ex_forw,
	output word_t    wb_forw,
	output wb_t      wb
);

	ex_ctrl_t ex_q;
	wb_t      wb_q;
	word_t    alu_res;

	////////////////////
	// EX control
	////////////////////

	// Loads whenever the pipe is not held, bubbles included
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			ex_q <= '0;
		end else if (!ex_freeze) begin
			ex_q <= ex_ctrl;
		end
	end

	assign ex_dst = ex_q;

	////////////////////
	// ALU
	////////////////////

	always_comb begin
		case (ex_q.op)
			op_add:  alu_res = operand_a + operand_b;
			op_sub:  alu_res = operand_a - operand_b;
			op_and:  alu_res = operand_a & operand_b;
			op_or:   alu_res = operand_a | operand_b;
			op_xor:  alu_res = operand_a ^ operand_b;
			op_shl:  alu_res = operand_a << operand_b[4:0];
			op_movb: alu_res = operand_b;
			default: alu_res = '0;
		endcase
	end

	// EX forwarding straight off the ALU
	assign ex_forw = alu_res;

	////////////////////
	// WB register
	////////////////////

	// Result and destination follow the EX control one stage later
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			wb_q <= '0;
		end else if (!ex_freeze) begin
			wb_q.valid <= ex_q.valid;
			wb_q.rd    <= ex_q.rd;
			wb_q.data  <= alu_res;
		end
	end

	assign wb_forw = wb_q.data;

	// Result shows for the one unfrozen cycle it sits in WB
	// so the register file write happens exactly once
	always_comb begin
		wb       = wb_q;
		wb.valid = wb_q.valid && !ex_freeze;
	end

endmodule

// File: flist.f
op_pkg.sv
regfile.sv
issue_decode.sv
operand_muxes.sv
exec_stage.sv
core_datapath.sv
datapath_properties.sv
tb_core_datapath.sv

// File: issue_decode.sv
// ID stage: instruction register, freeze pair and forwarding-select decode
`timescale 1ns/1ps

module issue_decode import op_pkg::*; (
	input  logic     clk,
	input  logic     rst_n,
	input  logic     issue_valid,
	input  logic     hold,
	input  issue_t   issue,
	output logic     issue_ready,
	output logic     id_freeze,
	output logic     ex_freeze,
	output reg_idx_t ra,
	output reg_idx_t rb,
	output opsel_t   sel_a,
	output opsel_t   sel_b,
	output word_t    simm,
	output ex_ctrl_t ex_ctrl,
	input  ex_ctrl_t ex_dst,
	input  wb_t      wb_dst
);

	issue_t id_q;
	logic   id_valid;
	logic   issue_fire;

	// Newest producer wins, register 0 never forwards
	function automatic opsel_t fwd_sel(input reg_idx_t src, input ex_ctrl_t ex_d, input wb_t wb_d);
		if (ex_d.valid && ex_d.rd != '0 && ex_d.rd == src)
			return sel_ex_forw;
		if (wb_d.valid && wb_d.rd != '0 && wb_d.rd == src)
			return sel_wb_forw;
		return sel_rf;
	endfunction

	////////////////////
	// Freeze pair
	////////////////////

	// The ID instruction always moves on with the next accepted one
	// so only hold blocks the port
	assign issue_ready = !hold;
	assign issue_fire  = issue_valid && issue_ready;
	assign ex_freeze   = hold;
	// ID keeps its instruction until a new one is taken
	assign id_freeze   = hold || !issue_fire;

	// ID instruction register
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			id_q     <= '0;
			id_valid <= 1'b0;
		end else if (!id_freeze) begin
			id_q     <= issue;
			id_valid <= 1'b1;
		end
	end

	////////////////////
	// Decode
	////////////////////

	assign ra    = id_q.ra;
	assign rb    = id_q.rb;
	assign simm  = {{(word_w-imm_w){id_q.imm[imm_w-1]}}, id_q.imm};
	assign sel_a = fwd_sel(id_q.ra, ex_dst, wb_dst);
	// Immediate overrides any forwarding match on rb
	assign sel_b = id_q.use_imm ? sel_imm : fwd_sel(id_q.rb, ex_dst, wb_dst);

	// Bubble into EX while ID sits frozen
	always_comb begin
		ex_ctrl.valid = id_valid && !id_freeze;
		ex_ctrl.op    = id_q.op;
		ex_ctrl.rd    = id_q.rd;
	end

endmodule

// File: op_pkg.sv
// Shared types for the operand front: word, index and select types, ALU operations, stage structs
package op_pkg;

	////////////////////
	// Widths and sizes
	////////////////////

	localparam int word_w   = 32;
	localparam int idx_w    = 5;
	localparam int imm_w    = 16;
	localparam int num_regs = 32;

	// Plain vector types
	typedef logic [word_w-1:0] word_t;
	typedef logic [idx_w-1:0]  reg_idx_t;
	typedef logic [imm_w-1:0]  imm_t;
	typedef logic [1:0]        opsel_t;

	////////////////////
	// Operand sources
	////////////////////

	// Immediate is a B-only source, A falls back to the register file
	localparam opsel_t sel_rf      = 2'd0;
	localparam opsel_t sel_imm     = 2'd1;
	localparam opsel_t sel_ex_forw = 2'd2;
	localparam opsel_t sel_wb_forw = 2'd3;

	// ALU operations
	typedef enum logic [2:0] {
		op_add,
		op_sub,
		op_and,
		op_or,
		op_xor,
		op_shl,   // shift A left by B[4:0]
		op_movb   // pass B through
	} alu_op_t;

	////////////////////
	// Stage records
	////////////////////

	// Instruction as offered on the issue port
	typedef struct packed {
		alu_op_t  op;
		reg_idx_t rd;
		reg_idx_t ra;
		reg_idx_t rb;
		imm_t     imm;
		logic     use_imm;
	} issue_t;

	// Control carried into EX
	typedef struct packed {
		logic     valid;
		alu_op_t  op;
		reg_idx_t rd;
	} ex_ctrl_t;

	// Writeback result, also the register file write
	typedef struct packed {
		logic     valid;
		reg_idx_t rd;
		word_t    data;
	} wb_t;

endpackage

// File: operand_muxes.sv
// Forwarding muxes for operands A and B and the freeze-aware operand registers
`timescale 1ns/1ps

module operand_muxes import op_pkg::*; (
	input  logic   clk,
	input  logic   rst_n,
	input  logic   id_freeze,
	input  logic   ex_freeze,
	input  word_t  rf_data_a,
	input  word_t  rf_data_b,
	input  word_t  ex_forw,
	input  word_t  wb_forw,
	input  word_t  simm,
	input  opsel_t sel_a,
	input  opsel_t sel_b,
	output word_t  operand_a,
	output word_t  operand_b
);

	// Lane 0 is operand A, lane 1 is operand B
	word_t muxed [2];
	word_t opnd_q [2];
	logic  saved_q [2];

	////////////////////
	// Source muxes
	////////////////////

	always_comb begin
		// Operand A, immediate select reads the register file
		case (sel_a)
			sel_ex_forw: muxed[0] = ex_forw;
			sel_wb_forw: muxed[0] = wb_forw;
			default:     muxed[0] = rf_data_a;
		endcase
		// Operand B
		case (sel_b)
			sel_imm:     muxed[1] = simm;
			sel_ex_forw: muxed[1] = ex_forw;
			sel_wb_forw: muxed[1] = wb_forw;
			default:     muxed[1] = rf_data_b;
		endcase
	end

	////////////////////
	// Operand registers
	////////////////////

	for (genvar i = 0; i < 2; i++) begin : g_lane
		always_ff @(posedge clk) begin
			if (!rst_n) begin
				opnd_q[i]  <= '0;
				saved_q[i] <= 1'b0;
			end else if (!ex_freeze && id_freeze && !saved_q[i]) begin
				// First edge of an ID-only freeze, capture while sources are fresh
				opnd_q[i]  <= muxed[i];
				saved_q[i] <= 1'b1;
			end else if (!ex_freeze && !saved_q[i]) begin
				// Normal advance
				opnd_q[i] <= muxed[i];
			end else if (!ex_freeze && !id_freeze) begin
				// Freeze over, held value goes on to EX
				saved_q[i] <= 1'b0;
			end
		end
	end

	assign operand_a = opnd_q[0];
	assign operand_b = opnd_q[1];

endmodule

// File: regfile.sv
// Register file with 32 words, two combinational read ports and one write port
`timescale 1ns/1ps

module regfile import op_pkg::*; (
	input  logic     clk,
	input  logic     rst_n,
	input  reg_idx_t rd_idx_a,
	input  reg_idx_t rd_idx_b,
	output word_t    rd_data_a,
	output word_t    rd_data_b,
	input  wb_t      wr
);

	// Register array
	// Only r1..r31 are stored, r0 is a constant zero
	word_t regs [1:num_regs-1];

	////////////////////
	// Write port
	////////////////////

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			for (int i = 1; i < num_regs; i++) begin
				regs[i] <= '0;
			end
		end else if (wr.valid && wr.rd != '0) begin
			// Lands at the edge that ends the WB cycle
			regs[wr.rd] <= wr.data;
		end
	end

	////////////////////
	// Read ports
	////////////////////

	// Index 0 reads as zero
	assign rd_data_a = (rd_idx_a == '0) ? '0 : regs[rd_idx_a];
	assign rd_data_b = (rd_idx_b == '0) ? '0 : regs[rd_idx_b];

endmodule

// File: run.sh
#!/bin/sh
# Build with Verilator, run, then decide from the simulation log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -f flist.f --top-module tb_core_datapath \
	-Mdir obj_dir -o sim_tb > build.log 2>&1 || { cat build.log; exit 1; }
./obj_dir/sim_tb > sim.log 2>&1
cat sim.log
grep -q "TEST FAIL" sim.log && exit 1 || grep -q "TEST PASS" sim.log || exit 1

// File: tb_core_datapath.sv
// Testbench: stimulus table, golden register model, result compare tasks, watchdog
`timescale 1ns/1ps

module tb_core_datapath import op_pkg::*; ();

	localparam int clk_period = 40;
	localparam int n_dir      = 32;
	localparam int n_rand     = 40;
	localparam int rb_base    = n_dir + n_rand;
	// Directed, random, 31 read-backs and one trailing instruction
	localparam int n_total    = rb_base + 31 + 1;

	// One stimulus row
	typedef struct packed {
		logic   valid;
		issue_t ins;
		logic   hold;
	} row_t;

	logic   clk;
	logic   rst_n;
	logic   issue_valid;
	logic   hold;
	issue_t issue;
	logic   issue_ready;
	wb_t    wb;

	row_t   rows [n_total];
	word_t  gold [num_regs];
	wb_t    exp_q [$];
	int     tag_q [$];
	wb_t    mon_exp;
	int     mon_tag;
	integer seed;

	core_datapath dut_i (
		.clk(clk), .rst_n(rst_n), .issue_valid(issue_valid), .hold(hold),
		.issue(issue), .issue_ready(issue_ready), .wb(wb)
	);

	always #(clk_period / 2) clk = ~clk;

	////////////////////
	// Helpers
	////////////////////

	task automatic abort_run();
		$display("TEST FAIL");
		$fatal(1, "stopped at first failure");
	endtask

	task automatic check_wb(input wb_t got, input wb_t exp);
		if (got !== exp) begin
			$display("** Error at %0t ns: wb rd=%0d data=%h, expected rd=%0d data=%h",
				$time, got.rd, got.data, exp.rd, exp.data);
			abort_run();
		end
	endtask

	task automatic check_word(input word_t got, input word_t exp, input int idx);
		if (got !== exp) begin
			$display("** Error at %0t ns: r%0d read back %h, expected %h", $time, idx, got, exp);
			abort_run();
		end
	endtask

	task automatic check_flag(input logic got, input logic exp, input string name);
		if (got !== exp) begin
			$display("** Error at %0t ns: %s is %b, expected %b", $time, name, got, exp);
			abort_run();
		end
	endtask

	function automatic row_t make_row(input logic v, input alu_op_t op, input reg_idx_t rd,
		input reg_idx_t ra, input reg_idx_t rb, input imm_t imm, input logic ui, input logic h);
		row_t r;
		r.valid       = v;
		r.ins.op      = op;
		r.ins.rd      = rd;
		r.ins.ra      = ra;
		r.ins.rb      = rb;
		r.ins.imm     = imm;
		r.ins.use_imm = ui;
		r.hold        = h;
		return r;
	endfunction

	function automatic word_t golden_alu(input alu_op_t op, input word_t a, input word_t b);
		case (op)
			op_add:  return a + b;
			op_sub:  return a - b;
			op_and:  return a & b;
			op_or:   return a | b;
			op_xor:  return a ^ b;
			op_shl:  return a << b[4:0];
			op_movb: return b;
			default: return '0;
		endcase
	endfunction

	// In-order reference execution at acceptance
	task automatic execute_golden(input issue_t ins, input int tag);
		word_t a;
		word_t b;
		wb_t   e;
		a = gold[ins.ra];
		b = ins.use_imm ? {{16{ins.imm[15]}}, ins.imm} : gold[ins.rb];
		e.valid = 1'b1;
		e.rd    = ins.rd;
		e.data  = golden_alu(ins.op, a, b);
		exp_q.push_back(e);
		tag_q.push_back(tag);
		if (ins.rd != '0)
			gold[ins.rd] = e.data;
	endtask

	////////////////////
	// Result monitor
	////////////////////

	// Mid-cycle sampling, wb is settled by then
	// Read-backs compare against the final golden register state
	always @(negedge clk) begin
		if (rst_n && wb.valid) begin
			if (exp_q.size() == 0) begin
				$display("A wb result for r%0d appeared with no instruction outstanding", wb.rd);
				abort_run();
			end else begin
				mon_exp = exp_q.pop_front();
				mon_tag = tag_q.pop_front();
				if (mon_tag > 0)
					check_word(wb.data, gold[mon_tag], mon_tag);
				else
					check_wb(wb, mon_exp);
			end
		end
	end

	initial begin
		#((n_total + 10) * clk_period);
		$display("Watchdog expired after %0d cycles with results still missing", n_total + 10);
		abort_run();
	end

	////////////////////
	// Stimulus
	////////////////////

	initial begin
		logic [31:0] r_ctl;
		logic [31:0] r_imm;
		int          tag;
		clk         = 1'b0;
		rst_n       = 1'b0;
		issue_valid = 1'b0;
		hold        = 1'b0;
		issue       = '0;
		seed        = 32'h8275_8bc3;
		for (int r = 0; r < num_regs; r++)
			gold[r] = '0;

		// Register file sources, r0 reads as zero
		rows[0]  = make_row(1'b1, op_movb, 1, 0, 0, 16'h0005, 1'b1, 1'b0);
		rows[1]  = make_row(1'b1, op_movb, 2, 0, 0, 16'hfffd, 1'b1, 1'b0);
		rows[2]  = make_row(1'b1, op_movb, 3, 0, 0, 16'h0100, 1'b1, 1'b0);
		rows[3]  = make_row(1'b1, op_movb, 4, 0, 0, 16'h7fff, 1'b1, 1'b0);
		rows[4]  = make_row(1'b1, op_add, 5, 1, 2, 0, 1'b0, 1'b0);
		rows[5]  = make_row(1'b1, op_add, 6, 0, 3, 0, 1'b0, 1'b0);
		// Back-to-back chains through EX on A and on B
		rows[6]  = make_row(1'b1, op_xor, 8, 6, 1, 0, 1'b0, 1'b0);
		rows[7]  = make_row(1'b1, op_add, 9, 8, 2, 0, 1'b0, 1'b0);
		rows[8]  = make_row(1'b1, op_or, 10, 1, 9, 0, 1'b0, 1'b0);
		rows[9]  = make_row(1'b1, op_shl, 11, 10, 1, 0, 1'b0, 1'b0);
		// WB forwarding while EX writes another register
		rows[10] = make_row(1'b1, op_add, 12, 3, 1, 0, 1'b0, 1'b0);
		rows[11] = make_row(1'b1, op_sub, 13, 2, 1, 0, 1'b0, 1'b0);
		rows[12] = make_row(1'b1, op_xor, 14, 12, 13, 0, 1'b0, 1'b0);
		rows[13] = make_row(1'b1, op_add, 15, 4, 12, 0, 1'b0, 1'b0);
		rows[14] = make_row(1'b1, op_or, 16, 14, 13, 0, 1'b0, 1'b0);
		// Immediate beats a matching rb
		rows[15] = make_row(1'b1, op_add, 17, 16, 16, 16'hfff0, 1'b1, 1'b0);
		rows[16] = make_row(1'b1, op_xor, 18, 17, 16, 16'h8001, 1'b1, 1'b0);
		// Hold cycles and issue gaps inside chains
		rows[17] = make_row(1'b0, op_add, 0, 0, 0, 0, 1'b0, 1'b1);
		rows[18] = make_row(1'b1, op_add, 19, 18, 17, 0, 1'b0, 1'b0);
		rows[19] = make_row(1'b0, op_add, 0, 0, 0, 0, 1'b0, 1'b0);
		rows[20] = make_row(1'b1, op_sub, 20, 19, 18, 0, 1'b0, 1'b0);
		rows[21] = make_row(1'b0, op_add, 0, 0, 0, 0, 1'b0, 1'b0);
		rows[22] = make_row(1'b0, op_add, 0, 0, 0, 0, 1'b0, 1'b0);
		rows[23] = make_row(1'b0, op_add, 0, 0, 0, 0, 1'b0, 1'b1);
		rows[24] = make_row(1'b1, op_xor, 21, 20, 19, 0, 1'b0, 1'b0);
		rows[25] = make_row(1'b1, op_add, 22, 21, 21, 0, 1'b0, 1'b1);   // refused
		rows[26] = make_row(1'b1, op_shl, 22, 21, 1, 0, 1'b0, 1'b0);
		rows[27] = make_row(1'b0, op_add, 0, 0, 0, 0, 1'b0, 1'b0);
		rows[28] = make_row(1'b0, op_add, 0, 0, 0, 0, 1'b0, 1'b1);
		rows[29] = make_row(1'b0, op_add, 0, 0, 0, 0, 1'b0, 1'b0);
		rows[30] = make_row(1'b1, op_add, 23, 22, 21, 0, 1'b0, 1'b0);
		rows[31] = make_row(1'b1, op_movb, 24, 0, 23, 0, 1'b0, 1'b0);

		// Random rows on r0..r15 so dependencies are frequent
		for (int i = 0; i < n_rand; i++) begin
			r_ctl = $random(seed);
			r_imm = $random(seed);
			rows[n_dir + i] = make_row(r_ctl[1:0] != 2'b00, alu_op_t'(r_ctl[22:20] % 3'd7),
				{1'b0, r_ctl[7:4]}, {1'b0, r_ctl[11:8]}, {1'b0, r_ctl[15:12]},
				r_imm[15:0], r_ctl[16], r_ctl[18:17] == 2'b11);
		end
		// Read-back of r1..r31, then one instruction that pushes the last out of ID
		for (int i = 0; i < 31; i++)
			rows[rb_base + i] = make_row(1'b1, op_movb, 0, 0, reg_idx_t'(i + 1), 0, 1'b0, 1'b0);
		rows[n_total - 1] = make_row(1'b1, op_add, 0, 0, 0, 0, 1'b0, 1'b0);

		repeat (2) @(posedge clk);
		#2;
		rst_n = 1'b1;
		@(negedge clk);
		check_flag(wb.valid, 1'b0, "wb.valid after reset");
		check_flag(issue_ready, 1'b1, "issue_ready after reset");

		for (int i = 0; i < n_total; i++) begin
			@(posedge clk);
			#2;
			issue_valid = rows[i].valid;
			issue       = rows[i].ins;
			hold        = rows[i].hold;
			#1;
			check_flag(issue_ready, !rows[i].hold, "issue_ready");
			tag = (i >= rb_base && i < rb_base + 31) ? i - rb_base + 1 : -1;
			// Taken only when offered and not held
			if (rows[i].valid && !rows[i].hold)
				execute_golden(rows[i].ins, tag);
		end
		@(posedge clk);
		#2;
		issue_valid = 1'b0;
		hold        = 1'b0;

		// Trailing instruction stays in ID, all others must retire
		while (exp_q.size() > 1)
			@(posedge clk);
		repeat (2) @(posedge clk);
		if (exp_q.size() != 1) begin
			$display("Result count is off, %0d instructions still without a wb result",
				exp_q.size());
			abort_run();
		end else begin
			$display("TEST PASS");
			$finish;
		end
	end

endmodule
